//--- design/dotp_pkg.sv
`default_nettype none

package dotp_pkg;

  typedef logic [63:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [2:0]  csr_addr_t;
  typedef logic [2:0]  lane_idx_t;
  typedef logic [3:0]  len_t;
  typedef logic [2:0]  credit_t;

  localparam int unsigned NUM_LANES   = 8;
  localparam int unsigned WORD_BYTES  = 8;
  localparam int unsigned MEM_CREDITS = 4;

  // register indices on the register port
  localparam csr_addr_t CSR_A_PTR   = 3'd0;
  localparam csr_addr_t CSR_B_PTR   = 3'd1;
  localparam csr_addr_t CSR_LEN     = 3'd2;
  localparam csr_addr_t CSR_START   = 3'd3;
  localparam csr_addr_t CSR_STATUS  = 3'd4;
  localparam csr_addr_t CSR_RES_PTR = 3'd5;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DRAIN,
    REDUCE,
    STORE,
    WAIT_ACK
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/dotp_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module dotp_csr_file (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire                        csr_cmd_v_i,
  input  wire                        csr_cmd_we_i,
  input  wire dotp_pkg::csr_addr_t   csr_cmd_addr_i,
  input  wire dotp_pkg::word_t       csr_cmd_data_i,
  input  wire                        busy_i,
  output logic                       csr_resp_v_o,
  output dotp_pkg::word_t            csr_resp_data_o,
  output logic                       start_o,
  output dotp_pkg::addr_t            a_ptr_o,
  output dotp_pkg::addr_t            b_ptr_o,
  output dotp_pkg::word_t            len_o,
  output dotp_pkg::addr_t            res_ptr_o
);

  dotp_pkg::addr_t a_ptr_q;
  dotp_pkg::addr_t b_ptr_q;
  dotp_pkg::addr_t res_ptr_q;
  dotp_pkg::word_t len_q;
  dotp_pkg::word_t start_q;
  dotp_pkg::word_t rd_data;
  logic            idle;
  logic            wr_en;

  // a start already in flight counts as busy
  assign idle  = ~(busy_i | start_o);
  assign wr_en = csr_cmd_v_i & csr_cmd_we_i;

  always_comb begin
    case (csr_cmd_addr_i)
      dotp_pkg::CSR_A_PTR:   rd_data = dotp_pkg::word_t'(a_ptr_q);
      dotp_pkg::CSR_B_PTR:   rd_data = dotp_pkg::word_t'(b_ptr_q);
      dotp_pkg::CSR_LEN:     rd_data = len_q;
      dotp_pkg::CSR_START:   rd_data = start_q;
      dotp_pkg::CSR_STATUS:  rd_data = {63'b0, idle};
      dotp_pkg::CSR_RES_PTR: rd_data = dotp_pkg::word_t'(res_ptr_q);
      default:               rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_q      <= '0;
      b_ptr_q      <= '0;
      res_ptr_q    <= '0;
      len_q        <= '0;
      start_q      <= '0;
      start_o      <= 1'b0;
      csr_resp_v_o <= 1'b0;
    end else begin
      csr_resp_v_o <= csr_cmd_v_i;
      start_o      <= 1'b0;
      if (wr_en) begin
        case (csr_cmd_addr_i)
          dotp_pkg::CSR_A_PTR:   a_ptr_q   <= dotp_pkg::addr_t'(csr_cmd_data_i);
          dotp_pkg::CSR_B_PTR:   b_ptr_q   <= dotp_pkg::addr_t'(csr_cmd_data_i);
          dotp_pkg::CSR_LEN:     len_q     <= csr_cmd_data_i;
          dotp_pkg::CSR_RES_PTR: res_ptr_q <= dotp_pkg::addr_t'(csr_cmd_data_i);
          dotp_pkg::CSR_START: begin
            start_q <= csr_cmd_data_i;
            start_o <= (csr_cmd_data_i != '0) & idle;
          end
          default: ;
        endcase
      end
    end
  end

  // read data is sampled with the command, old values on a write
  always_ff @(posedge clk_i) begin
    if (csr_cmd_v_i) begin
      csr_resp_data_o <= rd_data;
    end
  end

  assign a_ptr_o   = a_ptr_q;
  assign b_ptr_o   = b_ptr_q;
  assign len_o     = len_q;
  assign res_ptr_o = res_ptr_q;

endmodule

`default_nettype wire

//--- design/dotp_operand_buf.sv
`timescale 1ns/1ps
`default_nettype none

module dotp_operand_buf (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire                        clear_i,
  input  wire                        wr_i,
  input  wire                        wr_sel_b_i,
  input  wire dotp_pkg::lane_idx_t   wr_lane_i,
  input  wire dotp_pkg::word_t       wr_data_i,
  output dotp_pkg::word_t            a_lanes_o [dotp_pkg::NUM_LANES],
  output dotp_pkg::word_t            b_lanes_o [dotp_pkg::NUM_LANES]
);

  dotp_pkg::word_t a_q [dotp_pkg::NUM_LANES];
  dotp_pkg::word_t b_q [dotp_pkg::NUM_LANES];

  // lanes past the job length stay zero
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      a_q <= '{default: '0};
      b_q <= '{default: '0};
    end else if (wr_i) begin
      if (wr_sel_b_i) begin
        b_q[wr_lane_i] <= wr_data_i;
      end else begin
        a_q[wr_lane_i] <= wr_data_i;
      end
    end
  end

  assign a_lanes_o = a_q;
  assign b_lanes_o = b_q;

endmodule

`default_nettype wire

//--- design/dotp_reduce_tree.sv
`timescale 1ns/1ps
`default_nettype none

module dotp_reduce_tree (
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  wire                   start_i,
  input  wire dotp_pkg::word_t  a_lanes_i [dotp_pkg::NUM_LANES],
  input  wire dotp_pkg::word_t  b_lanes_i [dotp_pkg::NUM_LANES],
  output logic                  valid_o,
  output dotp_pkg::word_t       sum_o
);

  dotp_pkg::word_t prod_q [dotp_pkg::NUM_LANES];
  dotp_pkg::word_t sum_l1 [4];
  dotp_pkg::word_t sum_l2 [2];
  logic            prod_v_q;

  // products keep the low 64 bits
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      for (int i = 0; i < dotp_pkg::NUM_LANES; i++) begin
        prod_q[i] <= a_lanes_i[i] * b_lanes_i[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      sum_l1[i] = prod_q[2*i] + prod_q[2*i+1];
    end
    for (int i = 0; i < 2; i++) begin
      sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (prod_v_q) begin
      sum_o <= sum_l2[0] + sum_l2[1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prod_v_q <= 1'b0;
      valid_o  <= 1'b0;
    end else begin
      prod_v_q <= start_i;
      valid_o  <= prod_v_q;
    end
  end

endmodule

`default_nettype wire

//--- design/dotp_fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dotp_fetch_ctrl (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire                        start_i,
  input  wire dotp_pkg::addr_t       a_ptr_i,
  input  wire dotp_pkg::addr_t       b_ptr_i,
  input  wire dotp_pkg::word_t       len_i,
  input  wire dotp_pkg::addr_t       res_ptr_i,
  input  wire                        mem_resp_v_i,
  input  wire dotp_pkg::word_t       mem_resp_data_i,
  input  wire                        sum_v_i,
  input  wire dotp_pkg::word_t       sum_i,
  output logic                       busy_o,
  output logic                       mem_req_v_o,
  output logic                       mem_req_we_o,
  output dotp_pkg::addr_t            mem_req_addr_o,
  output dotp_pkg::word_t            mem_req_data_o,
  output logic                       buf_clear_o,
  output logic                       buf_wr_o,
  output logic                       buf_sel_b_o,
  output dotp_pkg::lane_idx_t        buf_lane_o,
  output dotp_pkg::word_t            buf_data_o,
  output logic                       tree_start_o
);

  dotp_pkg::ctrl_state_e state_q;
  dotp_pkg::len_t        len_q;
  dotp_pkg::len_t        len_sat;
  dotp_pkg::credit_t     credit_q;
  dotp_pkg::word_t       sum_q;
  dotp_pkg::addr_t       rd_base;
  logic [4:0]            issue_q;
  logic [4:0]            recv_q;
  logic [4:0]            len_ext;
  logic [4:0]            total;
  logic [4:0]            issue_off;
  logic [4:0]            recv_off;
  logic                  issue_b;
  logic                  all_issued;
  logic                  all_recv;
  logic                  have_credit;
  logic                  rd_issue;
  logic                  wr_issue;
  logic                  rd_resp;

  assign len_sat = (len_i > dotp_pkg::word_t'(dotp_pkg::NUM_LANES))
                 ? dotp_pkg::len_t'(dotp_pkg::NUM_LANES)
                 : dotp_pkg::len_t'(len_i);

  // A elements occupy k < len, B elements the rest
  assign len_ext     = {1'b0, len_q};
  assign total       = {len_q, 1'b0};
  assign issue_b     = issue_q >= len_ext;
  assign issue_off   = issue_b ? issue_q - len_ext : issue_q;
  assign buf_sel_b_o = recv_q >= len_ext;
  assign recv_off    = buf_sel_b_o ? recv_q - len_ext : recv_q;
  assign all_issued  = issue_q == total;
  assign all_recv    = recv_q == total;
  assign have_credit = credit_q != '0;

  assign rd_issue = (state_q == dotp_pkg::FETCH) & ~all_issued & have_credit;
  assign wr_issue = (state_q == dotp_pkg::STORE) & have_credit;
  assign rd_resp  = mem_resp_v_i &
                    ((state_q == dotp_pkg::FETCH) | (state_q == dotp_pkg::DRAIN));

  assign rd_base        = issue_b ? b_ptr_i : a_ptr_i;
  assign mem_req_v_o    = rd_issue | wr_issue;
  assign mem_req_we_o   = state_q == dotp_pkg::STORE;
  assign mem_req_addr_o = mem_req_we_o ? res_ptr_i
                        : rd_base + dotp_pkg::addr_t'(issue_off)
                          * dotp_pkg::addr_t'(dotp_pkg::WORD_BYTES);
  assign mem_req_data_o = sum_q;

  assign busy_o      = state_q != dotp_pkg::IDLE;
  assign buf_clear_o = (state_q == dotp_pkg::IDLE) & start_i;
  assign buf_wr_o    = rd_resp;
  assign buf_lane_o  = recv_off[2:0];
  assign buf_data_o  = mem_resp_data_i;

  // the buffer is complete once the last response has been written
  assign tree_start_o = ((state_q == dotp_pkg::FETCH) & all_issued & (len_q == '0)) |
                        ((state_q == dotp_pkg::DRAIN) & all_recv);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= dotp_pkg::IDLE;
      len_q    <= '0;
      issue_q  <= '0;
      recv_q   <= '0;
      credit_q <= dotp_pkg::credit_t'(dotp_pkg::MEM_CREDITS);
    end else begin
      case ({mem_req_v_o, mem_resp_v_i})
        2'b10:   credit_q <= credit_q - dotp_pkg::credit_t'(1);
        2'b01:   credit_q <= credit_q + dotp_pkg::credit_t'(1);
        default: ;
      endcase
      if (rd_issue) begin
        issue_q <= issue_q + 5'd1;
      end
      if (rd_resp) begin
        recv_q <= recv_q + 5'd1;
      end
      case (state_q)
        dotp_pkg::IDLE: begin
          if (start_i) begin
            len_q   <= len_sat;
            issue_q <= '0;
            recv_q  <= '0;
            state_q <= dotp_pkg::FETCH;
          end
        end
        dotp_pkg::FETCH: begin
          if (all_issued) begin
            state_q <= (len_q == '0) ? dotp_pkg::REDUCE : dotp_pkg::DRAIN;
          end
        end
        dotp_pkg::DRAIN:    if (all_recv) state_q <= dotp_pkg::REDUCE;
        dotp_pkg::REDUCE:   if (sum_v_i) state_q <= dotp_pkg::STORE;
        dotp_pkg::STORE:    if (wr_issue) state_q <= dotp_pkg::WAIT_ACK;
        dotp_pkg::WAIT_ACK: if (mem_resp_v_i) state_q <= dotp_pkg::IDLE;
        default:            state_q <= dotp_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == dotp_pkg::REDUCE) && sum_v_i) begin
      sum_q <= sum_i;
    end
  end

endmodule

`default_nettype wire

//--- design/dotp_accel.sv
`timescale 1ns/1ps
`default_nettype none

module dotp_accel (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire                        csr_cmd_v_i,
  input  wire                        csr_cmd_we_i,
  input  wire dotp_pkg::csr_addr_t   csr_cmd_addr_i,
  input  wire dotp_pkg::word_t       csr_cmd_data_i,
  output wire                        csr_resp_v_o,
  output wire dotp_pkg::word_t       csr_resp_data_o,
  output wire                        mem_req_v_o,
  output wire                        mem_req_we_o,
  output wire dotp_pkg::addr_t       mem_req_addr_o,
  output wire dotp_pkg::word_t       mem_req_data_o,
  input  wire                        mem_resp_v_i,
  input  wire dotp_pkg::word_t       mem_resp_data_i
);

  logic                busy;
  logic                start;
  dotp_pkg::addr_t     a_ptr;
  dotp_pkg::addr_t     b_ptr;
  dotp_pkg::addr_t     res_ptr;
  dotp_pkg::word_t     len;
  logic                buf_clear;
  logic                buf_wr;
  logic                buf_sel_b;
  dotp_pkg::lane_idx_t buf_lane;
  dotp_pkg::word_t     buf_data;
  dotp_pkg::word_t     a_lanes [dotp_pkg::NUM_LANES];
  dotp_pkg::word_t     b_lanes [dotp_pkg::NUM_LANES];
  logic                tree_start;
  logic                sum_v;
  dotp_pkg::word_t     sum;

  dotp_csr_file i_csr (
    .clk_i, .reset_i,
    .csr_cmd_v_i, .csr_cmd_we_i, .csr_cmd_addr_i, .csr_cmd_data_i,
    .busy_i(busy),
    .csr_resp_v_o, .csr_resp_data_o,
    .start_o(start),
    .a_ptr_o(a_ptr), .b_ptr_o(b_ptr), .len_o(len), .res_ptr_o(res_ptr)
  );

  dotp_fetch_ctrl i_ctrl (
    .clk_i, .reset_i,
    .start_i(start),
    .a_ptr_i(a_ptr), .b_ptr_i(b_ptr), .len_i(len), .res_ptr_i(res_ptr),
    .mem_resp_v_i, .mem_resp_data_i,
    .sum_v_i(sum_v), .sum_i(sum),
    .busy_o(busy),
    .mem_req_v_o, .mem_req_we_o, .mem_req_addr_o, .mem_req_data_o,
    .buf_clear_o(buf_clear), .buf_wr_o(buf_wr), .buf_sel_b_o(buf_sel_b),
    .buf_lane_o(buf_lane), .buf_data_o(buf_data),
    .tree_start_o(tree_start)
  );

  dotp_operand_buf i_buf (
    .clk_i, .reset_i,
    .clear_i(buf_clear), .wr_i(buf_wr), .wr_sel_b_i(buf_sel_b),
    .wr_lane_i(buf_lane), .wr_data_i(buf_data),
    .a_lanes_o(a_lanes), .b_lanes_o(b_lanes)
  );

  dotp_reduce_tree i_tree (
    .clk_i, .reset_i,
    .start_i(tree_start),
    .a_lanes_i(a_lanes), .b_lanes_i(b_lanes),
    .valid_o(sum_v), .sum_o(sum)
  );

endmodule

`default_nettype wire

//--- verif/dotp_accel_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module dotp_accel_assertions (
  input wire                      clk_i,
  input wire                      reset_i,
  input wire                      csr_cmd_v_i,
  input wire                      csr_resp_v_i,
  input wire                      busy_i,
  input wire                      mem_req_v_i,
  input wire                      mem_resp_v_i,
  input wire dotp_pkg::credit_t   credit_i
);

  logic error_seen;
  int   outstanding;

  initial error_seen = 1'b0;

  // requests sent and not yet answered, counted at the memory port
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(mem_req_v_i) - int'(mem_resp_v_i);
    end
  end

  credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_i <= dotp_pkg::credit_t'(dotp_pkg::MEM_CREDITS))
    else begin
      error_seen = 1'b1;
      $error("credit counter above the credit limit");
    end

  issue_needs_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_v_i |-> outstanding < int'(dotp_pkg::MEM_CREDITS))
    else begin
      error_seen = 1'b1;
      $error("memory request issued with no credit left");
    end

  resp_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_cmd_v_i |=> csr_resp_v_i)
    else begin
      error_seen = 1'b1;
      $error("register command got no response one cycle later");
    end

  resp_needs_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    csr_resp_v_i |-> $past(csr_cmd_v_i))
    else begin
      error_seen = 1'b1;
      $error("register response without a command one cycle earlier");
    end

  // the controller comes out of reset idle
  idle_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !busy_i)
    else begin
      error_seen = 1'b1;
      $error("controller busy right after reset");
    end

endmodule

`default_nettype wire

//--- verif/dotp_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dotp_mem_model #(
  parameter logic [31:0] SEED = 32'h9129b023
) (
  input  wire                    clk_i,
  input  wire                    reset_i,
  input  wire                    req_v_i,
  input  wire                    req_we_i,
  input  wire dotp_pkg::addr_t   req_addr_i,
  input  wire dotp_pkg::word_t   req_data_i,
  output logic                   resp_v_o,
  output dotp_pkg::word_t        resp_data_o,
  output logic                   overflow_o
);

  dotp_pkg::word_t mem [dotp_pkg::addr_t];
  dotp_pkg::word_t data_q [$];
  int unsigned     due_q [$];
  int unsigned     cycle;
  int unsigned     outstanding;
  int unsigned     due;
  logic [31:0]     lcg_state;

  // delay of 1 to 6 cycles
  function automatic int unsigned next_delay();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (int'(lcg_state[31:16]) % 6) + 1;
  endfunction

  initial begin
    lcg_state   = SEED;
    cycle       = 0;
    outstanding = 0;
    resp_v_o    = 1'b0;
    resp_data_o = '0;
    overflow_o  = 1'b0;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      data_q.delete();
      due_q.delete();
      outstanding = 0;
    end else begin
      cycle++;
      if (resp_v_o) outstanding--;
      if (req_v_i) begin
        outstanding++;
        if (outstanding > dotp_pkg::MEM_CREDITS) overflow_o = 1'b1;
        due = cycle + next_delay();
        // in order, at most one response per cycle
        if (due_q.size() > 0 && due <= due_q[$]) due = due_q[$] + 1;
        if (req_we_i) begin
          mem[req_addr_i] = req_data_i;
          data_q.push_back('0);
        end else if (mem.exists(req_addr_i)) begin
          data_q.push_back(mem[req_addr_i]);
        end else begin
          data_q.push_back({~req_addr_i, req_addr_i});
        end
        due_q.push_back(due);
      end
    end
    #1;
    if (due_q.size() > 0 && due_q[0] <= cycle) begin
      resp_v_o    = 1'b1;
      resp_data_o = data_q.pop_front();
      void'(due_q.pop_front());
    end else begin
      resp_v_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verif/dotp_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dotp_accel_tb;

  localparam int NUM_JOBS        = 12;
  localparam int WATCHDOG_CYCLES = NUM_JOBS * 2000;

  // each row holds the operand pointers, the result pointer, the length as
  // written and whether a second start is sent while busy
  localparam dotp_pkg::addr_t JOB_A_PTR [NUM_JOBS] = '{
    32'h0000_1000, 32'h0000_1400, 32'h0000_1800, 32'h0000_1c00,
    32'h0000_2000, 32'h0000_2400, 32'h0000_2800, 32'h0000_2c00,
    32'h0000_3000, 32'h0000_3400, 32'h0000_3800, 32'h8000_0000
  };
  localparam dotp_pkg::addr_t JOB_B_PTR [NUM_JOBS] = '{
    32'h0000_1200, 32'h0000_1600, 32'h0000_1a00, 32'h0000_1e00,
    32'h0000_2200, 32'h0000_2600, 32'h0000_2a00, 32'h0000_2e00,
    32'h0000_3200, 32'h0000_3600, 32'h0000_3a00, 32'hffff_fe00
  };
  localparam dotp_pkg::addr_t JOB_RES_PTR [NUM_JOBS] = '{
    32'h0000_8000, 32'h0000_8008, 32'h0000_8010, 32'h0000_8018,
    32'h0000_8020, 32'h0000_8028, 32'h0000_8030, 32'h0000_8038,
    32'h0000_8040, 32'h0000_8048, 32'h0000_8050, 32'hffff_fff8
  };
  localparam int JOB_LEN   [NUM_JOBS] = '{1, 2, 3, 4, 5, 6, 7, 8, 3, 0, 12, 8};
  localparam bit JOB_EXTRA_START [NUM_JOBS] = '{0, 0, 0, 1, 0, 0, 0, 0, 0, 1, 1, 0};

  logic                clk;
  logic                reset;
  logic                csr_cmd_v;
  logic                csr_cmd_we;
  dotp_pkg::csr_addr_t csr_cmd_addr;
  dotp_pkg::word_t     csr_cmd_data;
  logic                csr_resp_v;
  dotp_pkg::word_t     csr_resp_data;
  logic                mem_req_v;
  logic                mem_req_we;
  dotp_pkg::addr_t     mem_req_addr;
  dotp_pkg::word_t     mem_req_data;
  logic                mem_resp_v;
  dotp_pkg::word_t     mem_resp_data;
  logic                mem_overflow;
  logic [31:0]         lcg_state;
  dotp_pkg::addr_t     read_addr_q [$];
  dotp_pkg::addr_t     store_addr_q [$];
  dotp_pkg::word_t     store_data_q [$];
  dotp_pkg::word_t     a_vals [dotp_pkg::NUM_LANES];
  dotp_pkg::word_t     b_vals [dotp_pkg::NUM_LANES];

  dotp_accel i_dut (
    .clk_i(clk), .reset_i(reset),
    .csr_cmd_v_i(csr_cmd_v), .csr_cmd_we_i(csr_cmd_we),
    .csr_cmd_addr_i(csr_cmd_addr), .csr_cmd_data_i(csr_cmd_data),
    .csr_resp_v_o(csr_resp_v), .csr_resp_data_o(csr_resp_data),
    .mem_req_v_o(mem_req_v), .mem_req_we_o(mem_req_we),
    .mem_req_addr_o(mem_req_addr), .mem_req_data_o(mem_req_data),
    .mem_resp_v_i(mem_resp_v), .mem_resp_data_i(mem_resp_data)
  );

  dotp_mem_model #(.SEED(32'h9129b023)) i_mem (
    .clk_i(clk), .reset_i(reset),
    .req_v_i(mem_req_v), .req_we_i(mem_req_we),
    .req_addr_i(mem_req_addr), .req_data_i(mem_req_data),
    .resp_v_o(mem_resp_v), .resp_data_o(mem_resp_data), .overflow_o(mem_overflow)
  );

  bind dotp_accel dotp_accel_assertions i_assert (
    .clk_i, .reset_i, .csr_cmd_v_i, .csr_resp_v_i(csr_resp_v_o), .busy_i(busy),
    .mem_req_v_i(mem_req_v_o), .mem_resp_v_i, .credit_i(i_ctrl.credit_q)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input dotp_pkg::word_t got, input dotp_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input dotp_pkg::addr_t got, input dotp_pkg::addr_t exp,
                            input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_csr(input dotp_pkg::word_t got, input dotp_pkg::word_t exp,
                           input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: register read of %s gave %h, expected %h",
                              $time, what, got, exp));
    end
  endtask

  // starts and ends 1 ns after a rising edge
  task automatic csr_access(input logic we, input dotp_pkg::csr_addr_t addr,
                            input dotp_pkg::word_t wdata, output dotp_pkg::word_t rdata);
    csr_cmd_v    = 1'b1;
    csr_cmd_we   = we;
    csr_cmd_addr = addr;
    csr_cmd_data = wdata;
    @(posedge clk);
    #1;
    csr_cmd_v  = 1'b0;
    csr_cmd_we = 1'b0;
    if (csr_resp_v !== 1'b1) begin
      stop_on_error("the register port gave no response one cycle after a command");
    end
    rdata = csr_resp_data;
  endtask

  task automatic csr_write(input dotp_pkg::csr_addr_t addr, input dotp_pkg::word_t wdata);
    dotp_pkg::word_t unused;
    csr_access(1'b1, addr, wdata, unused);
  endtask

  task automatic csr_read(input dotp_pkg::csr_addr_t addr, output dotp_pkg::word_t rdata);
    csr_access(1'b0, addr, '0, rdata);
  endtask

  task automatic wait_idle();
    dotp_pkg::word_t status;
    status = '0;
    while (status != 64'd1) csr_read(dotp_pkg::CSR_STATUS, status);
  endtask

  // all eight lanes get data, so a job that reads too far would pick up nonzero terms
  task automatic load_operands(input dotp_pkg::addr_t a_ptr, input dotp_pkg::addr_t b_ptr);
    logic [31:0]     hi;
    logic [31:0]     lo;
    dotp_pkg::addr_t offset;
    for (int k = 0; k < dotp_pkg::NUM_LANES; k++) begin
      offset = dotp_pkg::addr_t'(k * dotp_pkg::WORD_BYTES);
      hi = lcg_next();
      lo = lcg_next();
      a_vals[k] = {hi, lo};
      hi = lcg_next();
      lo = lcg_next();
      b_vals[k] = {hi, lo};
      i_mem.mem[a_ptr + offset] = a_vals[k];
      i_mem.mem[b_ptr + offset] = b_vals[k];
    end
  endtask

  task automatic run_job(input int j);
    dotp_pkg::word_t rdata;
    dotp_pkg::word_t expected;
    dotp_pkg::addr_t offset;
    int              terms;
    // lengths above eight use all eight lanes
    terms = (JOB_LEN[j] > dotp_pkg::NUM_LANES) ? dotp_pkg::NUM_LANES : JOB_LEN[j];
    read_addr_q.delete();
    store_addr_q.delete();
    store_data_q.delete();
    load_operands(JOB_A_PTR[j], JOB_B_PTR[j]);
    csr_write(dotp_pkg::CSR_A_PTR, dotp_pkg::word_t'(JOB_A_PTR[j]));
    csr_write(dotp_pkg::CSR_B_PTR, dotp_pkg::word_t'(JOB_B_PTR[j]));
    csr_write(dotp_pkg::CSR_LEN, dotp_pkg::word_t'(JOB_LEN[j]));
    csr_write(dotp_pkg::CSR_RES_PTR, dotp_pkg::word_t'(JOB_RES_PTR[j]));
    csr_read(dotp_pkg::CSR_A_PTR, rdata);
    check_csr(rdata, dotp_pkg::word_t'(JOB_A_PTR[j]), "A pointer");
    csr_read(dotp_pkg::CSR_B_PTR, rdata);
    check_csr(rdata, dotp_pkg::word_t'(JOB_B_PTR[j]), "B pointer");
    csr_read(dotp_pkg::CSR_LEN, rdata);
    check_csr(rdata, dotp_pkg::word_t'(JOB_LEN[j]), "length");
    csr_read(dotp_pkg::CSR_RES_PTR, rdata);
    check_csr(rdata, dotp_pkg::word_t'(JOB_RES_PTR[j]), "result pointer");
    csr_write(dotp_pkg::CSR_START, 64'd1);
    csr_read(dotp_pkg::CSR_STATUS, rdata);
    check_csr(rdata, 64'd0, "STATUS during a job");
    if (JOB_EXTRA_START[j]) csr_write(dotp_pkg::CSR_START, 64'd1);
    wait_idle();
    // a wrongly accepted second start would store again within this window
    repeat (20) @(posedge clk);
    #1;
    expected = '0;
    for (int k = 0; k < terms; k++) expected += a_vals[k] * b_vals[k];
    check_word(dotp_pkg::word_t'(read_addr_q.size()), dotp_pkg::word_t'(2 * terms),
               "number of reads");
    for (int k = 0; k < terms; k++) begin
      offset = dotp_pkg::addr_t'(k * dotp_pkg::WORD_BYTES);
      check_addr(read_addr_q[k], JOB_A_PTR[j] + offset, "A read address");
      check_addr(read_addr_q[terms + k], JOB_B_PTR[j] + offset, "B read address");
    end
    check_word(dotp_pkg::word_t'(store_addr_q.size()), 64'd1, "number of stores");
    check_addr(store_addr_q[0], JOB_RES_PTR[j], "store address");
    check_word(store_data_q[0], expected, "stored dot product");
  endtask

  // outputs are stable mid-cycle
  always @(negedge clk) begin
    if (mem_overflow) begin
      stop_on_error("the memory saw more outstanding requests than the credit limit");
    end
    if (i_dut.i_assert.error_seen) begin
      stop_on_error("an assertion bound to the DUT failed");
    end
    if (!reset && mem_req_v) begin
      if (mem_req_we) begin
        store_addr_q.push_back(mem_req_addr);
        store_data_q.push_back(mem_req_data);
      end else begin
        read_addr_q.push_back(mem_req_addr);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_on_error($sformatf("timeout, the run did not finish within %0d cycles",
                            WATCHDOG_CYCLES));
  end

  initial begin
    dotp_pkg::word_t rdata;
    clk          = 1'b0;
    reset        = 1'b1;
    csr_cmd_v    = 1'b0;
    csr_cmd_we   = 1'b0;
    csr_cmd_addr = '0;
    csr_cmd_data = '0;
    lcg_state    = 32'h9129b023;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    if (csr_resp_v !== 1'b0 || mem_req_v !== 1'b0) begin
      stop_on_error($sformatf("FAILED at %0t: a valid output is high after reset", $time));
    end
    csr_read(dotp_pkg::CSR_STATUS, rdata);
    check_csr(rdata, 64'd1, "STATUS after reset");
    csr_read(3'd6, rdata);
    check_csr(rdata, 64'd0, "unmapped index 6");
    csr_read(3'd7, rdata);
    check_csr(rdata, 64'd0, "unmapped index 7");
    for (int j = 0; j < NUM_JOBS; j++) run_job(j);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dotp_accel.f
design/dotp_pkg.sv
design/dotp_csr_file.sv
design/dotp_operand_buf.sv
design/dotp_reduce_tree.sv
design/dotp_fetch_ctrl.sv
design/dotp_accel.sv
verif/dotp_accel_assertions.sv
verif/dotp_mem_model.sv
verif/dotp_accel_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dot-product accelerator testbench with Verilator
set -u
cd "$(dirname "$0")"

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module dotp_accel_tb -f dotp_accel.f -o vsim; then
  echo "verilator build failed"
  exit 1
fi

# assertion errors must not stop the run before the testbench reports them
./obj_dir/vsim +verilator+error+limit+10 > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
